// ==== files.f ====
rtl/mont_pkg.sv
rtl/multi_mode_multiplier.sv
rtl/redun_mont.sv
rtl/redun_to_canon.sv
rtl/mont_apb_regs.sv
rtl/mont_sq_top.sv
verif/mont_sq_tb.sv

// ==== rtl/mont_apb_regs.sv ====
// APB3 slave with no wait states; start is ignored while busy and ITERS of 0 runs one squaring
`default_nettype none
`timescale 1ns/1ps

module mont_apb_regs (
  input  logic                          i_clk,
  input  logic                          i_rst,
  input  logic                          i_psel,
  input  logic                          i_penable,
  input  logic                          i_pwrite,
  input  logic [7:0]                    i_paddr,
  input  logic [31:0]                   i_pwdata,
  output logic [31:0]                   o_prdata,
  output logic                          o_pready,
  output logic                          o_pslverr,
  output mont_pkg::redun0_t             o_sq,
  output logic                          o_sq_val,
  output logic                          o_stop,
  input  mont_pkg::redun0_t             i_mul,
  input  logic                          i_mul_val,
  output mont_pkg::redun0_t             o_canon_in,
  output logic                          o_canon_val,
  input  logic [mont_pkg::MOD_BITS-1:0] i_canon,
  input  logic                          i_canon_val,
  output logic                          o_irq
);

  logic                          access;
  logic                          wr_en;
  logic                          addr_hit;
  logic                          start;
  logic                          last_val;
  logic [15:0]                   iters_q;
  logic [15:0]                   iters_eff;
  logic [15:0]                   cnt_q;    // Engine results seen this run
  logic                          busy_q;
  logic                          done_q;
  logic [mont_pkg::MOD_BITS-1:0] op_q;
  logic [mont_pkg::MOD_BITS-1:0] res_q;
  mont_pkg::redun0_t             canon_in_q;

  assign access    = i_psel && i_penable;
  assign wr_en     = access && i_pwrite;
  assign start     = wr_en && i_paddr == mont_pkg::ADDR_CTRL && i_pwdata[0] && !busy_q;
  assign iters_eff = (iters_q == 16'd0) ? 16'd1 : iters_q;
  assign last_val  = busy_q && i_mul_val && cnt_q == iters_eff - 16'd1;

  always_comb begin
    o_prdata = '0;
    addr_hit = 1'b1;
    case (i_paddr)
      mont_pkg::ADDR_CTRL:   o_prdata = '0;  // Start is a write-only pulse
      mont_pkg::ADDR_STATUS: o_prdata = {30'd0, done_q, busy_q};
      mont_pkg::ADDR_ITERS:  o_prdata = {16'd0, iters_q};
      mont_pkg::ADDR_OP_LO:  o_prdata = op_q[31:0];
      mont_pkg::ADDR_OP_HI:  o_prdata = op_q[63:32];
      mont_pkg::ADDR_RES_LO: o_prdata = res_q[31:0];
      mont_pkg::ADDR_RES_HI: o_prdata = res_q[63:32];
      default:               addr_hit = 1'b0;
    endcase
  end

  assign o_pready  = access;
  assign o_pslverr = access && !addr_hit;

  always_ff @(posedge i_clk) begin
    if (i_rst) begin
      iters_q     <= '0;
      cnt_q       <= '0;
      busy_q      <= 1'b0;
      done_q      <= 1'b0;
      o_sq_val    <= 1'b0;
      o_stop      <= 1'b0;
      o_canon_val <= 1'b0;
    end else begin
      o_sq_val    <= start;
      o_stop      <= last_val;
      o_canon_val <= last_val;
      if (wr_en && i_paddr == mont_pkg::ADDR_ITERS) iters_q <= i_pwdata[15:0];
      if (start) begin
        busy_q <= 1'b1;
        done_q <= 1'b0;
        cnt_q  <= '0;
      end else if (busy_q && i_mul_val && !last_val) begin
        cnt_q <= cnt_q + 16'd1;
      end
      if (i_canon_val) begin
        busy_q <= 1'b0;
        done_q <= 1'b1;
      end
    end
  end

  always_ff @(posedge i_clk) begin
    if (wr_en && i_paddr == mont_pkg::ADDR_OP_LO) op_q[31:0]  <= i_pwdata;
    if (wr_en && i_paddr == mont_pkg::ADDR_OP_HI) op_q[63:32] <= i_pwdata;
    if (last_val)    canon_in_q <= i_mul;  // Final engine result only
    if (i_canon_val) res_q      <= i_canon;
  end

  assign o_sq       = mont_pkg::to_redun(op_q);
  assign o_canon_in = canon_in_q;
  assign o_irq      = done_q;

endmodule

`default_nettype wire

// ==== rtl/mont_pkg.sv ====
// Fixed odd modulus below R/4 and APB register map; MONT_FACTOR is derived at elaboration from P
`default_nettype none

package mont_pkg;

  localparam int WRD_BITS    = 16;
  localparam int NUM_WRDS    = 4;
  localparam int MOD_BITS    = WRD_BITS * NUM_WRDS;
  localparam int MULT_CYCLES = 2;
  // Column sum of NUM_WRDS products of two words with their carry bits, plus headroom
  localparam int MUL_COL_BITS = 2 * (WRD_BITS + 1) + $clog2(NUM_WRDS) + 1;

  localparam logic [MOD_BITS-1:0] P = 64'h2F3B_9A1D_C457_8E6B;

  // Word i carries weight 2^(WRD_BITS*i); bit WRD_BITS is a pending carry into word i+1
  typedef logic [NUM_WRDS-1:0][WRD_BITS:0]   redun0_t;
  typedef logic [2*NUM_WRDS-1:0][WRD_BITS:0] redun1_t;

  typedef enum logic [1:0] {
    FULL,      // Whole double-width product
    LOW,       // Low half only, top carries lost
    FULL_ADD   // Whole product with add term on the high half
  } mul_mode_t;

  localparam logic [7:0] ADDR_CTRL   = 8'h00;
  localparam logic [7:0] ADDR_STATUS = 8'h04;
  localparam logic [7:0] ADDR_ITERS  = 8'h08;
  localparam logic [7:0] ADDR_OP_LO  = 8'h0C;
  localparam logic [7:0] ADDR_OP_HI  = 8'h10;
  localparam logic [7:0] ADDR_RES_LO = 8'h14;
  localparam logic [7:0] ADDR_RES_HI = 8'h18;

  // Newton iteration for P^-1 mod R; each round doubles the number of correct bits
  function automatic logic [MOD_BITS-1:0] calc_mont_factor(input logic [MOD_BITS-1:0] p);
    logic [MOD_BITS-1:0] inv;
    inv = p;  // Already correct to 3 bits for odd p
    for (int i = 0; i < 6; i++) begin
      inv = inv * (MOD_BITS'(2) - p * inv);
    end
    return -inv;
  endfunction

  localparam logic [MOD_BITS-1:0] MONT_FACTOR = calc_mont_factor(P);

  function automatic redun0_t to_redun(input logic [MOD_BITS-1:0] v);
    redun0_t r;
    for (int i = 0; i < NUM_WRDS; i++) begin
      r[i] = {1'b0, v[i*WRD_BITS +: WRD_BITS]};  // Carry bit starts clear
    end
    return r;
  endfunction

endpackage

`default_nettype wire

// ==== rtl/mont_sq_top.sv ====
// Modulus is fixed at build time; host sees only the APB3 slave and a level interrupt
`default_nettype none
`timescale 1ns/1ps

module mont_sq_top (
  input  logic        i_clk,
  input  logic        i_rst,
  input  logic        i_psel,
  input  logic        i_penable,
  input  logic        i_pwrite,
  input  logic [7:0]  i_paddr,
  input  logic [31:0] i_pwdata,
  output logic [31:0] o_prdata,
  output logic        o_pready,
  output logic        o_pslverr,
  output logic        o_irq
);

  mont_pkg::redun0_t             sq;
  mont_pkg::redun0_t             mul;
  mont_pkg::redun0_t             canon_in;
  logic                          sq_val;
  logic                          stop;
  logic                          mul_val;
  logic                          canon_in_val;
  logic [mont_pkg::MOD_BITS-1:0] canon;
  logic                          canon_val;

  mont_apb_regs u_regs (
    .i_clk       (i_clk),
    .i_rst       (i_rst),
    .i_psel      (i_psel),
    .i_penable   (i_penable),
    .i_pwrite    (i_pwrite),
    .i_paddr     (i_paddr),
    .i_pwdata    (i_pwdata),
    .o_prdata    (o_prdata),
    .o_pready    (o_pready),
    .o_pslverr   (o_pslverr),
    .o_sq        (sq),
    .o_sq_val    (sq_val),
    .o_stop      (stop),
    .i_mul       (mul),
    .i_mul_val   (mul_val),
    .o_canon_in  (canon_in),
    .o_canon_val (canon_in_val),
    .i_canon     (canon),
    .i_canon_val (canon_val),
    .o_irq       (o_irq)
  );

  redun_mont u_mont (
    .i_clk  (i_clk),
    .i_rst  (i_rst),
    .i_sq   (sq),
    .i_val  (sq_val),
    .i_stop (stop),
    .o_mul  (mul),
    .o_val  (mul_val)
  );

  redun_to_canon u_canon (
    .i_clk (i_clk),
    .i_rst (i_rst),
    .i_dat (canon_in),
    .i_val (canon_in_val),
    .o_dat (canon),
    .o_val (canon_val)
  );

endmodule

`default_nettype wire

// ==== rtl/multi_mode_multiplier.sv ====
// Two pipeline stages, matching MULT_CYCLES; FULL_ADD assumes the product plus add term fits 2*MOD_BITS
`default_nettype none
`timescale 1ns/1ps

module multi_mode_multiplier (
  input  logic                i_clk,
  input  logic                i_rst,
  input  logic                i_val,
  input  mont_pkg::mul_mode_t i_mode,
  input  mont_pkg::redun0_t   i_dat_a,
  input  mont_pkg::redun0_t   i_dat_b,
  input  mont_pkg::redun0_t   i_add_term,
  output mont_pkg::redun1_t   o_dat,
  output logic                o_val
);

  logic [mont_pkg::MUL_COL_BITS-1:0]                   col_d [2*mont_pkg::NUM_WRDS];
  logic [mont_pkg::MUL_COL_BITS-1:0]                   col_q [2*mont_pkg::NUM_WRDS];
  logic [mont_pkg::MUL_COL_BITS-1:0]                   acc;
  logic [mont_pkg::MUL_COL_BITS-mont_pkg::WRD_BITS-1:0] carry;
  mont_pkg::mul_mode_t                                 mode_q;
  mont_pkg::redun0_t                                   add_q;
  mont_pkg::redun1_t                                   res_d;
  logic                                                val_q;

  // Schoolbook partial products summed per column
  always_comb begin
    for (int k = 0; k < 2*mont_pkg::NUM_WRDS; k++) begin
      col_d[k] = '0;
    end
    for (int i = 0; i < mont_pkg::NUM_WRDS; i++) begin
      for (int j = 0; j < mont_pkg::NUM_WRDS; j++) begin
        col_d[i+j] = col_d[i+j] + mont_pkg::MUL_COL_BITS'(i_dat_a[i])
                                * mont_pkg::MUL_COL_BITS'(i_dat_b[j]);
      end
    end
  end

  always_ff @(posedge i_clk) begin
    col_q  <= col_d;
    mode_q <= i_mode;
    add_q  <= i_add_term;
  end

  // Low bits stay in the word, the rest moves up a column
  always_comb begin
    carry = '0;
    for (int k = 0; k < 2*mont_pkg::NUM_WRDS; k++) begin
      acc      = col_q[k] + mont_pkg::MUL_COL_BITS'(carry);
      carry    = acc[mont_pkg::MUL_COL_BITS-1:mont_pkg::WRD_BITS];
      res_d[k] = {1'b0, acc[mont_pkg::WRD_BITS-1:0]};
    end
    if (mode_q == mont_pkg::FULL_ADD) begin
      // Word-wise add, the carry bit of each word absorbs the overflow
      for (int k = 0; k < mont_pkg::NUM_WRDS; k++) begin
        res_d[mont_pkg::NUM_WRDS+k] = res_d[mont_pkg::NUM_WRDS+k] + add_q[k];
      end
    end
    if (mode_q == mont_pkg::LOW) begin
      for (int k = 0; k < mont_pkg::NUM_WRDS; k++) begin
        res_d[mont_pkg::NUM_WRDS+k] = '0;
      end
    end
  end

  always_ff @(posedge i_clk) begin
    o_dat <= res_d;
  end

  always_ff @(posedge i_clk) begin
    if (i_rst) begin
      val_q <= 1'b0;
      o_val <= 1'b0;
    end else begin
      val_q <= i_val;
      o_val <= val_q;  // Valid travels with the data
    end
  end

  // The engine sequencing relies on this exact latency
  a_lat_fwd: assert property (@(posedge i_clk) disable iff (i_rst)
    i_val |-> ##(mont_pkg::MULT_CYCLES) o_val);
  a_lat_back: assert property (@(posedge i_clk) disable iff (i_rst)
    o_val |-> $past(i_val, mont_pkg::MULT_CYCLES));

endmodule

`default_nettype wire

// ==== rtl/redun_mont.sv ====
// One squaring chain at a time; i_val is taken only in IDLE and the operand must be below 2P
`default_nettype none
`timescale 1ns/1ps

module redun_mont (
  input  logic              i_clk,
  input  logic              i_rst,
  input  mont_pkg::redun0_t i_sq,
  input  logic              i_val,
  input  logic              i_stop,
  output mont_pkg::redun0_t o_mul,
  output logic              o_val
);

  typedef enum logic [1:0] {IDLE, SQR, RED_LO, RED_HI} state_t;

  state_t              state_q;
  logic                issue_q;   // One-cycle valid into the multiplier
  mont_pkg::redun0_t   cur_q;     // Operand of the next squaring
  mont_pkg::redun0_t   t_hi_q;    // High half of a*a
  mont_pkg::redun0_t   low_q;     // Low half of a*a, later m
  logic                lo_nz_q;
  mont_pkg::redun0_t   mul_a;
  mont_pkg::redun0_t   mul_b;
  mont_pkg::redun0_t   add_term;
  mont_pkg::mul_mode_t mul_mode;
  mont_pkg::redun1_t   mul_dat;
  logic                mul_val;

  always_ff @(posedge i_clk) begin
    if (i_rst) begin
      state_q <= IDLE;
      issue_q <= 1'b0;
      o_val   <= 1'b0;
    end else begin
      issue_q <= 1'b0;
      o_val   <= 1'b0;
      case (state_q)
        IDLE: begin
          if (i_val) begin
            state_q <= SQR;
            issue_q <= 1'b1;
          end
        end
        SQR: begin
          if (mul_val) begin
            state_q <= RED_LO;
            issue_q <= 1'b1;
          end
        end
        RED_LO: begin
          if (mul_val) begin
            state_q <= RED_HI;
            issue_q <= 1'b1;
          end
        end
        RED_HI: begin
          if (mul_val) begin
            state_q <= SQR;  // Result goes straight back into the next squaring
            issue_q <= 1'b1;
            o_val   <= 1'b1;
          end
        end
        default: state_q <= IDLE;
      endcase
      if (i_stop) begin
        state_q <= IDLE;
        issue_q <= 1'b0;
      end
    end
  end

  // Pass results
  always_ff @(posedge i_clk) begin
    if (state_q == IDLE && i_val) begin
      cur_q <= i_sq;
    end
    if (mul_val) begin
      case (state_q)
        SQR: begin
          t_hi_q  <= mul_dat[2*mont_pkg::NUM_WRDS-1:mont_pkg::NUM_WRDS];
          low_q   <= mul_dat[mont_pkg::NUM_WRDS-1:0];
          lo_nz_q <= |mul_dat[mont_pkg::NUM_WRDS-1:0];
        end
        RED_LO: low_q <= mul_dat[mont_pkg::NUM_WRDS-1:0];  // m = T_lo * MONT_FACTOR mod R
        RED_HI: cur_q <= mul_dat[2*mont_pkg::NUM_WRDS-1:mont_pkg::NUM_WRDS];
        default: ;
      endcase
    end
  end

  // Carry out of T_lo + m*P into the high half is 1 exactly when T_lo is nonzero
  always_comb begin
    add_term    = t_hi_q;
    add_term[0] = t_hi_q[0] + {{mont_pkg::WRD_BITS{1'b0}}, lo_nz_q};
  end

  always_comb begin
    mul_a    = cur_q;
    mul_b    = cur_q;
    mul_mode = mont_pkg::FULL;
    case (state_q)
      RED_LO: begin
        mul_a    = low_q;
        mul_b    = mont_pkg::to_redun(mont_pkg::MONT_FACTOR);
        mul_mode = mont_pkg::LOW;
      end
      RED_HI: begin
        mul_a    = low_q;
        mul_b    = mont_pkg::to_redun(mont_pkg::P);
        mul_mode = mont_pkg::FULL_ADD;
      end
      default: ;
    endcase
  end

  assign o_mul = cur_q;  // Updated on the same edge that raises o_val

  multi_mode_multiplier u_mult (
    .i_clk      (i_clk),
    .i_rst      (i_rst),
    .i_val      (issue_q),
    .i_mode     (mul_mode),
    .i_dat_a    (mul_a),
    .i_dat_b    (mul_b),
    .i_add_term (add_term),
    .o_dat      (mul_dat),
    .o_val      (mul_val)
  );

  // The register block must hold off a new start until the chain has been stopped
  a_start_idle: assert property (@(posedge i_clk) disable iff (i_rst)
    i_val |-> state_q == IDLE);

endmodule

`default_nettype wire

// ==== rtl/redun_to_canon.sv ====
// Input value must be below 2P so that a single subtraction of P gives a canonical result
`default_nettype none
`timescale 1ns/1ps

module redun_to_canon (
  input  logic                          i_clk,
  input  logic                          i_rst,
  input  mont_pkg::redun0_t             i_dat,
  input  logic                          i_val,
  output logic [mont_pkg::MOD_BITS-1:0] o_dat,
  output logic                          o_val
);

  logic [mont_pkg::WRD_BITS+1:0] acc;
  logic [1:0]                    carry;
  logic [mont_pkg::MOD_BITS-1:0] flat;  // Value with all carries resolved
  logic                          ge_p;

  // Ripple the pending carry bits up through the words
  always_comb begin
    carry = '0;
    for (int i = 0; i < mont_pkg::NUM_WRDS; i++) begin
      acc = {1'b0, i_dat[i]} + {{mont_pkg::WRD_BITS{1'b0}}, carry};
      flat[i*mont_pkg::WRD_BITS +: mont_pkg::WRD_BITS] = acc[mont_pkg::WRD_BITS-1:0];
      carry = acc[mont_pkg::WRD_BITS+1:mont_pkg::WRD_BITS];
    end
  end

  assign ge_p = (flat >= mont_pkg::P);

  always_ff @(posedge i_clk) begin
    if (i_val) begin
      o_dat <= ge_p ? flat - mont_pkg::P : flat;
    end
  end

  always_ff @(posedge i_clk) begin
    if (i_rst) o_val <= 1'b0;
    else       o_val <= i_val;
  end

endmodule

`default_nettype wire

// ==== run.sh ====
#!/bin/sh
# Build and run with Verilator, then decide pass or fail from the log
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log
verilator --binary --timing --assert --top-module mont_sq_tb -f files.f -o mont_sq_sim \
  && ./obj_dir/mont_sq_sim > sim.log 2>&1
cat sim.log 2>/dev/null
grep -q "NO ERRORS" sim.log && echo "PASS" || { echo "FAIL"; exit 1; }

// ==== verif/mont_sq_tb.sv ====
// Drives the engine over APB only; expected results come from a bit-serial Montgomery model
`default_nettype none
`timescale 1ns/1ps

module mont_sq_tb;

  localparam int NUM_ROWS    = 14;
  localparam int NUM_FIXED   = 4;
  localparam int ROW_RESTART = 6;    // This row gets a second start while busy
  localparam int APB_TIMEOUT = 16;
  localparam int DONE_POLLS  = 500;
  localparam logic [7:0] ADDR_UNMAPPED = 8'h40;

  logic        clk;
  logic        rst;
  logic        psel;
  logic        penable;
  logic        pwrite;
  logic [7:0]  paddr;
  logic [31:0] pwdata;
  logic [31:0] prdata;
  logic        pready;
  logic        pslverr;
  logic        irq;

  logic [31:0]                   rng_state;
  logic [mont_pkg::MOD_BITS-1:0] op_tbl    [NUM_ROWS];
  logic [15:0]                   iters_tbl [NUM_ROWS];
  logic [mont_pkg::MOD_BITS-1:0] exp_tbl   [NUM_ROWS];

  mont_sq_top mont_sq_top_i (
    .i_clk     (clk),
    .i_rst     (rst),
    .i_psel    (psel),
    .i_penable (penable),
    .i_pwrite  (pwrite),
    .i_paddr   (paddr),
    .i_pwdata  (pwdata),
    .o_prdata  (prdata),
    .o_pready  (pready),
    .o_pslverr (pslverr),
    .o_irq     (irq)
  );

  always #4 clk = ~clk;

  function automatic logic [31:0] xorshift32(input logic [31:0] s);
    logic [31:0] x;
    x = s;
    x = x ^ (x << 13);
    x = x ^ (x >> 17);
    x = x ^ (x << 5);
    return x;
  endfunction

  // Divides a*a by R one bit at a time, then reduces below P
  function automatic logic [63:0] mont_square(input logic [63:0] a);
    logic [127:0] x;
    x = {64'd0, a} * {64'd0, a};
    for (int i = 0; i < mont_pkg::MOD_BITS; i++) begin
      if (x[0]) x = x + 128'(mont_pkg::P);  // Make it even without changing the class
      x = x >> 1;
    end
    if (x >= 128'(mont_pkg::P)) x = x - 128'(mont_pkg::P);
    return x[63:0];
  endfunction

  function automatic logic [63:0] mont_model(input logic [63:0] a, input logic [15:0] iters);
    logic [63:0] v;
    int          n;
    v = a;
    n = (iters == 16'd0) ? 1 : int'(iters);
    for (int i = 0; i < n; i++) begin
      v = mont_square(v);
    end
    return v;
  endfunction

  task automatic abort_run(input string why);
    $display("ERRORS FOUND");
    $fatal(1, "%s", why);
  endtask

  task automatic check_word(input string name, input logic [31:0] got, input logic [31:0] exp);
    if (got !== exp) begin
      $display("error: %s got 0x%h expected 0x%h", name, got, exp);
      abort_run("register read value mismatch");
    end
  endtask

  task automatic check_flag(input string name, input logic got, input logic exp);
    if (got !== exp) begin
      $display("error: %s got 0x%h expected 0x%h", name, got, exp);
      abort_run("status flag mismatch");
    end
  endtask

  task automatic apb_access(input logic wr, input logic [7:0] addr, input logic [31:0] wdata,
                            output logic [31:0] rdata, output logic err);
    int n;
    n = 0;
    @(posedge clk);
    psel    <= 1'b1;  // Setup phase
    penable <= 1'b0;
    pwrite  <= wr;
    paddr   <= addr;
    pwdata  <= wdata;
    @(posedge clk);
    penable <= 1'b1;
    @(negedge clk);
    while (!pready) begin
      n++;
      if (n > APB_TIMEOUT) abort_run("APB access phase never saw pready");
      @(negedge clk);
    end
    rdata = prdata;
    err   = pslverr;
    @(posedge clk);
    psel    <= 1'b0;
    penable <= 1'b0;
    pwrite  <= 1'b0;
  endtask

  task automatic apb_write(input logic [7:0] addr, input logic [31:0] wdata);
    logic [31:0] unused_rd;
    logic        err;
    apb_access(1'b1, addr, wdata, unused_rd, err);
    check_flag("o_pslverr", err, 1'b0);
  endtask

  task automatic apb_read(input logic [7:0] addr, output logic [31:0] rdata);
    logic err;
    apb_access(1'b0, addr, 32'd0, rdata, err);
    check_flag("o_pslverr", err, 1'b0);
  endtask

  // Polls status until done while busy holds
  task automatic wait_done();
    logic [31:0] st;
    int          polls;
    polls = 0;
    apb_read(mont_pkg::ADDR_STATUS, st);
    while (!st[1]) begin
      check_flag("busy", st[0], 1'b1);
      polls++;
      if (polls > DONE_POLLS) abort_run("done bit never set after start");
      apb_read(mont_pkg::ADDR_STATUS, st);
    end
    check_flag("busy", st[0], 1'b0);
  endtask

  task automatic build_table();
    logic [63:0] hi;
    logic [63:0] lo;
    op_tbl[0] = 64'd0;
    op_tbl[1] = 64'd1;
    op_tbl[2] = 64'((128'd1 << mont_pkg::MOD_BITS) % 128'(mont_pkg::P));  // R mod P
    op_tbl[3] = mont_pkg::P - 64'd1;
    for (int i = 0; i < NUM_FIXED; i++) begin
      iters_tbl[i] = 16'd1;
    end
    for (int i = NUM_FIXED; i < NUM_ROWS; i++) begin
      rng_state    = xorshift32(rng_state);
      hi           = {32'd0, rng_state};
      rng_state    = xorshift32(rng_state);
      lo           = {32'd0, rng_state};
      op_tbl[i]    = ((hi << 32) | lo) % mont_pkg::P;
      rng_state    = xorshift32(rng_state);
      iters_tbl[i] = 16'(rng_state % 32'd20) + 16'd1;
    end
    iters_tbl[ROW_RESTART] = 16'd20;  // Long enough to still be busy at the second start
    for (int i = 0; i < NUM_ROWS; i++) begin
      exp_tbl[i] = mont_model(op_tbl[i], iters_tbl[i]);
    end
  endtask

  task automatic run_row(input int idx);
    logic [31:0] rd;
    logic [31:0] res_lo;
    logic [31:0] res_hi;
    apb_write(mont_pkg::ADDR_OP_LO, op_tbl[idx][31:0]);
    apb_write(mont_pkg::ADDR_OP_HI, op_tbl[idx][63:32]);
    apb_write(mont_pkg::ADDR_ITERS, {16'd0, iters_tbl[idx]});
    apb_read(mont_pkg::ADDR_ITERS, rd);
    check_word("iters", rd, {16'd0, iters_tbl[idx]});
    apb_write(mont_pkg::ADDR_CTRL, 32'd1);
    apb_read(mont_pkg::ADDR_STATUS, rd);
    check_flag("busy", rd[0], 1'b1);
    check_flag("done", rd[1], 1'b0);  // Cleared by the new start
    @(negedge clk);
    check_flag("o_irq", irq, 1'b0);
    if (idx == ROW_RESTART) begin
      apb_write(mont_pkg::ADDR_CTRL, 32'd1);  // Must be ignored
      apb_read(mont_pkg::ADDR_STATUS, rd);
      check_flag("busy", rd[0], 1'b1);
    end
    wait_done();
    @(negedge clk);
    check_flag("o_irq", irq, 1'b1);
    apb_read(mont_pkg::ADDR_RES_LO, res_lo);
    apb_read(mont_pkg::ADDR_RES_HI, res_hi);
    check_flag("res_below_p", {res_hi, res_lo} < mont_pkg::P, 1'b1);
    check_word("res_lo", res_lo, exp_tbl[idx][31:0]);
    check_word("res_hi", res_hi, exp_tbl[idx][63:32]);
  endtask

  initial begin
    logic [31:0] rd;
    logic        err;
    clk       = 1'b0;
    rst       = 1'b1;
    psel      = 1'b0;
    penable   = 1'b0;
    pwrite    = 1'b0;
    paddr     = 8'd0;
    pwdata    = 32'd0;
    rng_state = 32'h791c;
    build_table();
    repeat (10) @(posedge clk);
    rst <= 1'b0;
    @(posedge clk);

    apb_read(mont_pkg::ADDR_STATUS, rd);
    check_word("status", rd, 32'd0);
    @(negedge clk);
    check_flag("o_irq", irq, 1'b0);

    apb_access(1'b0, ADDR_UNMAPPED, 32'd0, rd, err);
    check_flag("o_pslverr", err, 1'b1);

    for (int i = 0; i < NUM_ROWS; i++) begin
      run_row(i);
    end

    $display("NO ERRORS");
    $finish;
  end

endmodule

`default_nettype wire
